// File: src/loudness_defines.svh
`ifndef LOUDNESS_DEFINES_SVH
`define LOUDNESS_DEFINES_SVH

// Signed sample width from the codec
`define SAMPLE_W   16
`define NUM_MICS   4     // One energy lane per microphone

// Samples per angle step, power of two
`define FRAME_LEN  64
`define NUM_ANGLES 360   // Full turn, one frame per step
`define ANGLE_W    9

// Square doubles the width, the frame sum adds log2(FRAME_LEN)
`define ENERGY_W   38
// Plus log2(NUM_MICS) for the sum over lanes
`define LOUD_W     40

`endif

// File: src/loudness_pkg.sv
`include "loudness_defines.svh"

package loudness_pkg;

    typedef logic signed [`SAMPLE_W-1:0] sample_t;      // One microphone sample
    typedef sample_t [`NUM_MICS-1:0]     mic_vec_t;     // Index m is microphone m

    typedef logic [`ENERGY_W-1:0] energy_t;             // Sum of squares of one lane
    typedef logic [`LOUD_W-1:0]   loud_t;               // Sum over all lanes
    typedef logic [`ANGLE_W-1:0]  angle_t;

    // Position of a sample inside its frame
    typedef struct packed {
        logic valid;
        logic first;    // Accumulator restarts
        logic last;     // Frame closes
    } frame_ctl_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        SCAN = 2'd1,
        DONE = 2'd2
    } scan_state_t;

    // Loudest angle so far
    typedef struct packed {
        angle_t angle;
        loud_t  loudness;
    } peak_t;

endpackage

// File: src/frame_sequencer.sv
`timescale 1ns/100ps
`include "loudness_defines.svh"

module frame_sequencer import loudness_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        sample_valid,
    input  mic_vec_t    mics,
    input  logic        frame_stored,   // Store wrote one angle
    output frame_ctl_t  ctl,
    output mic_vec_t    mics_q,
    output angle_t      frame_angle,    // Angle of the frame that is closing
    output logic        busy,
    output logic        done
);

    localparam int CNT_W = $clog2(`FRAME_LEN);

    scan_state_t      state;
    logic [CNT_W-1:0] sample_cnt;       // Position inside the frame
    angle_t           angle_cnt;        // Current angle step
    logic             take;
    logic             last_sample;
    logic             last_angle;

    assign take        = (state == SCAN) && sample_valid;      // Strobes outside SCAN are dropped
    assign last_sample = (sample_cnt == CNT_W'(`FRAME_LEN - 1));
    assign last_angle  = (angle_cnt == `ANGLE_W'(`NUM_ANGLES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            sample_cnt <= '0;
            angle_cnt  <= '0;
            ctl        <= '0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            ctl <= '0;                  // Flags are single-cycle
            case (state)
                IDLE, DONE: begin
                    if (start) begin    // Fresh scan from angle 0
                        state      <= SCAN;
                        sample_cnt <= '0;
                        angle_cnt  <= '0;
                        busy       <= 1'b1;
                        done       <= 1'b0;
                    end else if (state == DONE && frame_stored) begin
                        done <= 1'b1;   // Last angle has landed in memory
                    end
                end
                SCAN: begin
                    if (sample_valid) begin
                        ctl.valid  <= 1'b1;
                        ctl.first  <= (sample_cnt == '0);
                        ctl.last   <= last_sample;
                        sample_cnt <= sample_cnt + 1'b1;   // Wraps at frame end
                        if (last_sample) begin
                            angle_cnt <= angle_cnt + 1'b1;
                            if (last_angle) begin
                                state <= DONE;  // Drain continues in the lanes
                                busy  <= 1'b0;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Sample and angle tag ride alongside ctl
    always_ff @(posedge clk) begin
        if (take) begin
            mics_q <= mics;
        end
        if (take && last_sample) begin
            frame_angle <= angle_cnt;   // Held until the next frame closes
        end
    end

endmodule

// File: src/mic_energy.sv
`timescale 1ns/100ps
`include "loudness_defines.svh"

module mic_energy import loudness_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  frame_ctl_t ctl,
    input  sample_t    sample,
    output energy_t    energy,          // Frame energy, valid with energy_valid
    output logic       energy_valid
);

    logic [2*`SAMPLE_W-1:0] square;     // Never negative, fits unsigned
    energy_t                acc;
    energy_t                acc_next;

    // Signed product, sign-extended operands in 32-bit context
    assign square = sample * sample;

    // Restart on first so no clear cycle is needed between frames
    assign acc_next = (ctl.first ? energy_t'(0) : acc) + energy_t'(square);

    always_ff @(posedge clk) begin
        if (rst) begin
            energy_valid <= 1'b0;
        end else begin
            energy_valid <= ctl.valid && ctl.last;  // One cycle after last
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.valid) begin
            acc <= acc_next;
        end
        if (ctl.valid && ctl.last) begin
            energy <= acc_next;     // Includes the closing sample
        end
    end

endmodule

// File: src/angle_loudness_store.sv
`timescale 1ns/100ps
`include "loudness_defines.svh"

module angle_loudness_store import loudness_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,          // Clears peak only
    input  energy_t [`NUM_MICS-1:0]   energy,
    input  logic                      energy_valid,   // Lane 0 speaks for all
    input  angle_t                    frame_angle,
    input  angle_t                    rd_angle,
    output loud_t                     rd_loudness,
    output peak_t                     peak,
    output logic                      frame_stored
);

    loud_t mem [0:`NUM_ANGLES-1];       // Loudness per angle step
    loud_t frame_loud;
    logic  louder;

    // Sum over lanes, LOUD_W leaves room for every carry
    always_comb begin
        frame_loud = '0;
        for (int i = 0; i < `NUM_MICS; i++) begin
            frame_loud = frame_loud + loud_t'(energy[i]);
        end
    end

    // Strictly greater, so a tie keeps the earlier angle
    assign louder = (frame_loud > peak.loudness);

    always_ff @(posedge clk) begin
        if (rst) begin
            peak         <= '0;
            frame_stored <= 1'b0;
        end else begin
            frame_stored <= energy_valid;   // Same edge as the memory write
            if (start) begin
                peak <= '0;
            end else if (energy_valid && louder) begin
                peak.angle    <= frame_angle;
                peak.loudness <= frame_loud;
            end
        end
    end

    // Memory write port
    always_ff @(posedge clk) begin
        if (energy_valid) begin
            mem[frame_angle] <= frame_loud;
        end
    end

    // Readback, one cycle of latency
    always_ff @(posedge clk) begin
        rd_loudness <= mem[rd_angle];
    end

endmodule

// File: src/hex_display.sv
`timescale 1ns/100ps
`include "loudness_defines.svh"

module hex_display import loudness_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  peak_t            peak,
    output logic [3:0][6:0]  hex        // Active low, segment g in bit 6
);

    logic [3:0][3:0] nib;

    // Seven-segment pattern for one hex digit
    function automatic logic [6:0] seg7(input logic [3:0] value);
        case (value)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;     // F
        endcase
    endfunction

    assign nib[0] = peak.angle[3:0];
    assign nib[1] = peak.angle[7:4];
    assign nib[2] = {3'b000, peak.angle[8]};            // Angle tops out at 0x167
    assign nib[3] = peak.loudness[`LOUD_W-1 -: 4];      // Coarse level, top nibble

    always_ff @(posedge clk) begin
        for (int d = 0; d < 4; d++) begin
            hex[d] <= rst ? seg7(4'h0) : seg7(nib[d]);  // Shows zeros out of reset
        end
    end

endmodule

// File: src/loudness_scanner.sv
`timescale 1ns/100ps
`include "loudness_defines.svh"

module loudness_scanner import loudness_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             sample_valid,
    input  mic_vec_t         mics,
    input  angle_t           rd_angle,
    output logic             busy,
    output logic             done,
    output loud_t            rd_loudness,
    output peak_t            peak,
    output logic [3:0][6:0]  hex
);

    frame_ctl_t                ctl;
    mic_vec_t                  mics_q;
    angle_t                    frame_angle;
    logic                      frame_stored;
    energy_t [`NUM_MICS-1:0]   energy;
    logic [`NUM_MICS-1:0]      energy_valid;    // Lanes run in lockstep

    frame_sequencer u_frame_sequencer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .sample_valid (sample_valid),
        .mics         (mics),
        .frame_stored (frame_stored),
        .ctl          (ctl),
        .mics_q       (mics_q),
        .frame_angle  (frame_angle),
        .busy         (busy),
        .done         (done)
    );

    for (genvar m = 0; m < `NUM_MICS; m++) begin : g_lane
        mic_energy u_mic_energy (
            .clk          (clk),
            .rst          (rst),
            .ctl          (ctl),              // Shared framing
            .sample       (mics_q[m]),
            .energy       (energy[m]),
            .energy_valid (energy_valid[m])
        );
    end

    angle_loudness_store u_angle_loudness_store (
        .clk          (clk),
        .rst          (rst),
        .start        (start && !busy),       // Start inside a scan is ignored
        .energy       (energy),
        .energy_valid (energy_valid[0]),
        .frame_angle  (frame_angle),
        .rd_angle     (rd_angle),
        .rd_loudness  (rd_loudness),
        .peak         (peak),
        .frame_stored (frame_stored)
    );

    hex_display u_hex_display (
        .clk  (clk),
        .rst  (rst),
        .peak (peak),
        .hex  (hex)
    );

endmodule

// File: sim/loudness_scanner_assert.sv
`timescale 1ns/100ps
`include "loudness_defines.svh"

module loudness_scanner_assert (
    input logic                  clk,
    input logic                  rst,
    input logic [`NUM_MICS-1:0]  energy_valid,   // One per lane
    input logic                  frame_stored,
    input logic                  busy,
    input logic                  done
);

    int fail_count;                 // Read by the testbench at the end
    initial fail_count = 0;

    // Lanes share one ctl, so their pulses coincide
    lanes_agree: assert property (@(posedge clk) disable iff (rst)
        (energy_valid == '0) || (energy_valid == '1))
        else begin
            $error("Lane energy_valid pulses differ: %b", energy_valid);
            fail_count++;
        end

    // Store acknowledges each frame on the next edge
    stored_after_valid: assert property (@(posedge clk) disable iff (rst)
        energy_valid[0] |=> frame_stored)
        else begin
            $error("frame_stored missing after energy_valid");
            fail_count++;
        end

    stored_only_after_valid: assert property (@(posedge clk) disable iff (rst)
        frame_stored |-> $past(energy_valid[0]))
        else begin
            $error("frame_stored without energy_valid one cycle before");
            fail_count++;
        end

    busy_done_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(busy && done))
        else begin
            $error("busy and done high together");
            fail_count++;
        end

endmodule

// Top level is the one scope where all lane valids meet
bind loudness_scanner loudness_scanner_assert u_scanner_assert (
    .clk          (clk),
    .rst          (rst),
    .energy_valid (energy_valid),
    .frame_stored (frame_stored),
    .busy         (busy),
    .done         (done)
);

// File: sim/tb_loudness_scanner.sv
`timescale 1ns/100ps
`include "loudness_defines.svh"

module tb_loudness_scanner import loudness_pkg::*; ();

    localparam int PERIOD_NS   = 4;
    // Strobes average 75 percent, so twice the sample count bounds one scan
    localparam int SCAN_CYCLES = 2 * `NUM_ANGLES * `FRAME_LEN + 2 * `NUM_ANGLES
                               + 4 * `FRAME_LEN + 100;
    localparam int WATCHDOG_NS = 2 * 2 * SCAN_CYCLES * PERIOD_NS;   // Two scans, doubled
    localparam logic [6:0] SEG_TABLE [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
        7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

    logic clk, rst, start, sample_valid, busy, done;
    mic_vec_t mics;
    angle_t rd_angle;
    loud_t rd_loudness;
    peak_t peak;
    logic [3:0][6:0] hex;
    integer seed;
    loud_t model_loud [`NUM_ANGLES];    // Expected memory contents
    peak_t model_peak;
    mic_vec_t cur_frame [`FRAME_LEN];
    mic_vec_t peak_frame [`FRAME_LEN];  // Replayed at the last angle to force a tie

    loudness_scanner dut_i (
        .clk(clk), .rst(rst), .start(start), .sample_valid(sample_valid), .mics(mics),
        .rd_angle(rd_angle), .busy(busy), .done(done), .rd_loudness(rd_loudness),
        .peak(peak), .hex(hex)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before both scans finished");
        $display("Something failed");
        $fatal(1, "Timeout");
    end

    initial begin
        wait (dut_i.u_scanner_assert.fail_count != 0);
        $display("A bound assertion failed");
        $display("Something failed");
        $fatal(1, "Assertion failure");
    end

    task automatic check_loud(input string name, input loud_t got, input loud_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1, "Loudness mismatch");
        end
    endtask

    task automatic check_peak(input string name, input peak_t got, input peak_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1, "Peak mismatch");
        end
    endtask

    task automatic check_hex(input string name, input logic [3:0][6:0] got,
                             input logic [3:0][6:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1, "Digit mismatch");
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1, "Level mismatch");
        end
    endtask

    function automatic mic_vec_t random_vec();
        mic_vec_t v;
        for (int m = 0; m < `NUM_MICS; m++) v[m] = sample_t'($random(seed));
        return v;
    endfunction

    // Sum of squares over all microphones for one sample set
    function automatic loud_t set_energy(input mic_vec_t smp);
        loud_t sum;
        longint v;
        sum = '0;
        for (int m = 0; m < `NUM_MICS; m++) begin
            v = smp[m];                 // Sign extends
            sum += loud_t'(v * v);
        end
        return sum;
    endfunction

    function automatic logic [3:0][6:0] expected_hex(input peak_t p);
        logic [3:0][6:0] d;
        d[0] = SEG_TABLE[p.angle[3:0]];
        d[1] = SEG_TABLE[p.angle[7:4]];
        d[2] = SEG_TABLE[{3'b000, p.angle[8]}];
        d[3] = SEG_TABLE[p.loudness[`LOUD_W-1 -: 4]];
        return d;
    endfunction

    // Idle cycles at about 25 percent, then one strobe with smp
    task automatic drive_sample(input mic_vec_t smp);
        @(negedge clk);
        while (($random(seed) & 3) == 0) begin
            sample_valid = 1'b0;
            mics = random_vec();        // Junk, not strobed
            @(negedge clk);
        end
        sample_valid = 1'b1;
        mics = smp;
    endtask

    task automatic run_scan();
        loud_t frame_loud;
        mic_vec_t smp;
        @(negedge clk);
        start = 1'b1;
        sample_valid = 1'b0;
        @(negedge clk);
        start = 1'b0;
        check_level("busy", busy, 1'b1);
        check_peak("peak", peak, '0);   // Cleared by start
        model_peak = '0;
        for (int a = 0; a < `NUM_ANGLES; a++) begin
            frame_loud = '0;
            for (int n = 0; n < `FRAME_LEN; n++) begin
                smp = (a == `NUM_ANGLES - 1) ? peak_frame[n] : random_vec();
                cur_frame[n] = smp;
                drive_sample(smp);
                frame_loud += set_energy(smp);
            end
            model_loud[a] = frame_loud;
            if (frame_loud > model_peak.loudness) begin   // Strictly greater keeps ties
                model_peak.angle = angle_t'(a);
                model_peak.loudness = frame_loud;
                peak_frame = cur_frame;
            end
        end
        // done on the third edge after the last strobe, later strobes ignored
        for (int k = 1; k <= `FRAME_LEN + 8; k++) begin
            @(negedge clk);
            sample_valid = 1'b1;
            mics = {`NUM_MICS{16'h8000}};   // Largest square, would beat any random peak
            check_level("done", done, k >= 4);
            check_level("busy", busy, 1'b0);
        end
        sample_valid = 1'b0;
        check_peak("peak", peak, model_peak);
        check_hex("hex", hex, expected_hex(model_peak));
        for (int a = 0; a < `NUM_ANGLES; a++) begin
            @(negedge clk);
            rd_angle = angle_t'(a);
            @(negedge clk);
            check_loud("rd_loudness", rd_loudness, model_loud[a]);
        end
    endtask

    initial begin
        seed = 32'h5d14f3c7;
        rst = 1'b1;
        start = 1'b0;
        sample_valid = 1'b0;
        mics = '0;
        rd_angle = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_level("busy", busy, 1'b0);
        check_level("done", done, 1'b0);
        check_peak("peak", peak, '0);
        check_hex("hex", hex, expected_hex('0));
        for (int k = 0; k < 2 * `FRAME_LEN; k++) begin   // Strobes before start, over a frame
            @(negedge clk);
            sample_valid = 1'b1;
            mics = random_vec();
            rd_angle = angle_t'(k);
            check_level("busy", busy, 1'b0);
        end
        check_peak("peak", peak, '0);   // No frame closed in IDLE
        run_scan();
        run_scan();                     // New data, same checks
        $display("Everything OK");
        $finish;
    end

endmodule

// File: loudness_scanner.f
+incdir+src
src/loudness_pkg.sv
src/frame_sequencer.sv
src/mic_energy.sv
src/angle_loudness_store.sv
src/hex_display.sv
src/loudness_scanner.sv
sim/loudness_scanner_assert.sv
sim/tb_loudness_scanner.sv

// File: Bender.yml
package:
  name: loudness_scanner

export_include_dirs:
  - src

sources:
  - files:
      - src/loudness_pkg.sv
      - src/frame_sequencer.sv
      - src/mic_energy.sv
      - src/angle_loudness_store.sv
      - src/hex_display.sv
      - src/loudness_scanner.sv
  - target: test
    files:
      - sim/loudness_scanner_assert.sv
      - sim/tb_loudness_scanner.sv
